// ==== Bender.yml ====
package:
  name: camera_capture

sources:
  - camera_pkg.sv
  - stream_pkg.sv
  - camera_input_sync.sv
  - pixel_position_counter.sv
  - capture_fsm.sv
  - chunk_stacker.sv
  - camera_capture_top.sv
  - target: test
    files:
      - tb_camera_capture.sv

// ==== camera_capture_top.sv ====
`default_nettype none

module camera_capture_top import camera_pkg::*, stream_pkg::*; #(
  parameter int h_active = default_h_active,
  parameter int v_active = default_v_active
) (
  input  logic      clk_camera,
  input  logic      sys_rst,
  input  cam_pins_t cam,
  output chunk_t    chunk,
  output logic      chunk_valid,
  input  logic      chunk_ready,
  output logic      overrun
);

  logic       pix_strobe;
  pixel_t     pix_data;
  logic       hsync_fall;
  logic       vsync_level;
  pixel_pos_t pix;
  logic       pix_valid;
  logic       frame_start;
  logic       capture_en;
  logic       chunk_overflow;

  camera_input_sync camera_input_sync_inst (
    .clk_camera  (clk_camera),
    .sys_rst     (sys_rst),
    .cam         (cam),
    .pix_strobe  (pix_strobe),
    .pix_data    (pix_data),
    .hsync_fall  (hsync_fall),
    .vsync_level (vsync_level)
  );

  pixel_position_counter #(
    .h_active (h_active),
    .v_active (v_active)
  ) pixel_position_counter_inst (
    .clk_camera  (clk_camera),
    .sys_rst     (sys_rst),
    .frame_start (frame_start),
    .pix_strobe  (pix_strobe),
    .pix_data    (pix_data),
    .hsync_fall  (hsync_fall),
    .pix         (pix),
    .pix_valid   (pix_valid)
  );

  capture_fsm capture_fsm_inst (
    .clk_camera     (clk_camera),
    .sys_rst        (sys_rst),
    .vsync_level    (vsync_level),
    .chunk_overflow (chunk_overflow),
    .frame_start    (frame_start),
    .capture_en     (capture_en),
    .overrun        (overrun)
  );

  chunk_stacker #(
    .h_active (h_active),
    .v_active (v_active)
  ) chunk_stacker_inst (
    .clk_camera     (clk_camera),
    .sys_rst        (sys_rst),
    .pix            (pix),
    .pix_valid      (pix_valid),
    .capture_en     (capture_en),
    .frame_start    (frame_start),
    .chunk          (chunk),
    .chunk_valid    (chunk_valid),
    .chunk_ready    (chunk_ready),
    .chunk_overflow (chunk_overflow)
  );

endmodule

`default_nettype wire

// ==== camera_input_sync.sv ====
`default_nettype none

module camera_input_sync import camera_pkg::*; (
  input  logic      clk_camera,
  input  logic      sys_rst,
  input  cam_pins_t cam,
  output logic      pix_strobe,
  output pixel_t    pix_data,
  output logic      hsync_fall,
  output logic      vsync_level
);

  cam_pins_t cam_meta;  // first stage, may go metastable
  cam_pins_t cam_sync;
  logic      pclk_prev;
  logic      hsync_prev;

  always_ff @(posedge clk_camera) begin
    cam_meta <= cam;
    cam_sync <= cam_meta;
  end

  // edge detection on the synchronized pins
  always_ff @(posedge clk_camera) begin
    if (sys_rst) begin
      pclk_prev   <= 1'b0;
      hsync_prev  <= 1'b0;
      pix_strobe  <= 1'b0;
      hsync_fall  <= 1'b0;
      vsync_level <= 1'b0;
    end else begin
      pclk_prev   <= cam_sync.pclk;
      hsync_prev  <= cam_sync.hsync;
      // only pclk rises inside an active line carry a pixel
      pix_strobe  <= cam_sync.pclk && !pclk_prev && cam_sync.hsync;
      hsync_fall  <= hsync_prev && !cam_sync.hsync;  // end of line
      vsync_level <= cam_sync.vsync;
    end
  end

  // data sampled on the same edge as the strobe
  always_ff @(posedge clk_camera) begin
    pix_data <= cam_sync.data;
  end

endmodule

`default_nettype wire

// ==== camera_pkg.sv ====
`default_nettype none

// camera side types: pin bundle, pixels and their positions
package camera_pkg;

  typedef logic [7:0]  pixel_t;   // luminance only
  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;

  // raw parallel camera pins, 11 bits
  typedef struct packed {
    logic [7:0] data;
    logic       pclk;
    logic       hsync;
    logic       vsync;
  } cam_pins_t;

  // one pixel tagged with where it sits in the frame
  typedef struct packed {
    pixel_t  pixel;
    hcount_t hcount;
    vcount_t vcount;
  } pixel_pos_t;

  localparam int default_h_active = 1280;
  localparam int default_v_active = 720;

endpackage

`default_nettype wire

// ==== capture_fsm.sv ====
`default_nettype none

module capture_fsm (
  input  logic clk_camera,
  input  logic sys_rst,
  input  logic vsync_level,
  input  logic chunk_overflow,
  output logic frame_start,
  output logic capture_en,
  output logic overrun
);

  typedef enum logic [1:0] {
    wait_vsync,  // out of reset, find a frame gap
    wait_start,  // in vertical blanking
    capture,
    drop         // rest of frame thrown away after back-pressure
  } state_t;

  state_t state;

  always_ff @(posedge clk_camera) begin
    if (sys_rst) begin
      state       <= wait_vsync;
      frame_start <= 1'b0;
      overrun     <= 1'b0;
    end else begin
      frame_start <= 1'b0;
      if (chunk_overflow) begin
        overrun <= 1'b1;  // sticky until reset
      end
      case (state)
        wait_vsync: begin
          if (vsync_level) begin
            state <= wait_start;
          end
        end
        wait_start: begin
          // vsync dropping marks the first line coming
          if (!vsync_level) begin
            state       <= capture;
            frame_start <= 1'b1;
          end
        end
        capture: begin
          if (vsync_level) begin
            state <= wait_start;
          end else if (chunk_overflow) begin
            state <= drop;
          end
        end
        drop: begin
          if (vsync_level) begin
            state <= wait_start;
          end
        end
        default: state <= wait_vsync;
      endcase
    end
  end

  assign capture_en = (state == capture);

  // an overflow stops capture on the next cycle and is remembered
  overflow_stops_capture: assert property (
    @(posedge clk_camera) disable iff (sys_rst)
    chunk_overflow |=> !capture_en && overrun
  );

endmodule

`default_nettype wire

// ==== chunk_stacker.sv ====
`default_nettype none

module chunk_stacker import camera_pkg::*, stream_pkg::*; #(
  parameter int h_active = default_h_active,
  parameter int v_active = default_v_active
) (
  input  logic       clk_camera,
  input  logic       sys_rst,
  input  pixel_pos_t pix,
  input  logic       pix_valid,
  input  logic       capture_en,
  input  logic       frame_start,
  output chunk_t     chunk,
  output logic       chunk_valid,
  input  logic       chunk_ready,
  output logic       chunk_overflow
);

  localparam int cnt_width = $clog2(pixels_per_chunk);

  logic [chunk_width-1:0] pack_data;  // packer, filled from the top
  logic [cnt_width-1:0]   pack_cnt;
  logic                   keep;
  logic                   complete;
  logic                   is_final;
  logic                   stage_free;

  // 2:1 downsample in both directions
  assign keep = pix_valid && capture_en && !pix.hcount[0] && !pix.vcount[0];
  assign complete = keep && (pack_cnt == cnt_width'(pixels_per_chunk - 1));

  // last kept pixel of the frame always closes a chunk
  assign is_final = (pix.hcount == hcount_t'(h_active - 2)) &&
                    (pix.vcount == vcount_t'(v_active - 2));

  // output stage empties on the same edge a beat is taken
  assign stage_free = !chunk_valid || chunk_ready;
  assign chunk_overflow = complete && !stage_free;

  always_ff @(posedge clk_camera) begin
    if (sys_rst || frame_start) begin
      pack_cnt <= '0;  // partial chunk discarded
    end else if (keep) begin
      pack_cnt <= pack_cnt + 1'b1;  // wraps after the 16th
    end
  end

  // shift right so the oldest pixel ends in bits 7:0
  always_ff @(posedge clk_camera) begin
    if (keep) begin
      pack_data <= {pix.pixel, pack_data[chunk_width-1:8]};
    end
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst) begin
      chunk_valid <= 1'b0;
    end else if (complete && stage_free) begin
      chunk_valid <= 1'b1;
    end else if (chunk_ready) begin
      chunk_valid <= 1'b0;
    end
  end

  // held chunk only replaced once free, overflowed chunk is lost
  always_ff @(posedge clk_camera) begin
    if (complete && stage_free) begin
      chunk.data <= {pix.pixel, pack_data[chunk_width-1:8]};
      chunk.last <= is_final;
    end
  end

  chunk_held_stable: assert property (
    @(posedge clk_camera) disable iff (sys_rst)
    chunk_valid && !chunk_ready |=> chunk_valid && $stable(chunk)
  );

endmodule

`default_nettype wire

// ==== pixel_position_counter.sv ====
`default_nettype none

module pixel_position_counter import camera_pkg::*; #(
  parameter int h_active = default_h_active,
  parameter int v_active = default_v_active
) (
  input  logic       clk_camera,
  input  logic       sys_rst,
  input  logic       frame_start,
  input  logic       pix_strobe,
  input  pixel_t     pix_data,
  input  logic       hsync_fall,
  output pixel_pos_t pix,
  output logic       pix_valid
);

  hcount_t hcount;
  vcount_t vcount;

  // strobe and hsync fall never coincide, hsync differs between them
  always_ff @(posedge clk_camera) begin
    if (sys_rst || frame_start) begin
      hcount <= '0;
      vcount <= '0;
    end else if (hsync_fall) begin
      hcount <= '0;             // new line
      vcount <= vcount + 1'b1;
    end else if (pix_strobe) begin
      hcount <= hcount + 1'b1;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst) begin
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= pix_strobe;
    end
  end

  // pixel tagged with the count before it advances
  always_ff @(posedge clk_camera) begin
    if (pix_strobe) begin
      pix.pixel  <= pix_data;
      pix.hcount <= hcount;
      pix.vcount <= vcount;
    end
  end

  // a camera sending more pixels per line than configured breaks packing
  hcount_in_range: assert property (
    @(posedge clk_camera) disable iff (sys_rst)
    pix_valid |-> pix.hcount < h_active
  );

endmodule

`default_nettype wire

// ==== src.f ====
camera_pkg.sv
stream_pkg.sv
camera_input_sync.sv
pixel_position_counter.sv
capture_fsm.sv
chunk_stacker.sv
camera_capture_top.sv
tb_camera_capture.sv

// ==== stream_pkg.sv ====
`default_nettype none

// output stream beat format
package stream_pkg;

  localparam int pixels_per_chunk = 16;
  localparam int chunk_width      = 128;  // pixels_per_chunk bytes

  // first kept pixel lands in data[7:0]
  typedef struct packed {
    logic [chunk_width-1:0] data;
    logic                   last;  // final chunk of the frame
  } chunk_t;

endpackage

`default_nettype wire

// ==== tb_camera_capture.sv ====
`default_nettype none

module tb_camera_capture import camera_pkg::*, stream_pkg::*;;

  localparam int h_active = 64;
  localparam int v_active = 4;
  localparam int frame_cycles = 32 + v_active * (h_active * 8 + 24);
  localparam int timeout_cycles = 8 * frame_cycles;  // five frames, an idle line and margin

  logic      clk_camera;
  logic      sys_rst;
  cam_pins_t cam;
  chunk_t    chunk;
  logic      chunk_valid;
  logic      chunk_ready;
  logic      overrun;

  chunk_t                 rx_q[$];   // beats taken from the DUT
  chunk_t                 exp_q[$];  // beats built from the kept-pixel rule
  logic [chunk_width-1:0] exp_data;
  int                     exp_n;
  int                     error_count;
  int                     checks_done;
  int                     cycle_count = 0;
  logic [31:0]            pix_lfsr;
  logic [31:0]            ready_lfsr;
  logic                   frame_done;

  camera_capture_top #(
    .h_active (h_active),
    .v_active (v_active)
  ) camera_capture_top_inst (
    .clk_camera  (clk_camera),
    .sys_rst     (sys_rst),
    .cam         (cam),
    .chunk       (chunk),
    .chunk_valid (chunk_valid),
    .chunk_ready (chunk_ready),
    .overrun     (overrun)
  );

  initial begin
    clk_camera = 1'b0;
    forever #10 clk_camera = ~clk_camera;
  end

  always @(posedge clk_camera) begin
    if (chunk_valid && chunk_ready) begin
      rx_q.push_back(chunk);
    end
  end

  always @(posedge clk_camera) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_pixel(output pixel_t b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      pix_lfsr = lfsr_step(pix_lfsr);
      b = {b[6:0], pix_lfsr[0]};
    end
  endtask

  task automatic ready_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      ready_lfsr = lfsr_step(ready_lfsr);
      v = (v << 1) | ready_lfsr[0];
    end
  endtask

  task automatic check_chunk(input chunk_t got, input chunk_t exp, input string what);
    checks_done++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s got %h last %b, expected %h last %b", $time, what,
               got.data, got.last, exp.data, exp.last);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks_done++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_number(input int got, input int exp, input string what);
    checks_done++;
    if (got != exp) begin
      error_count++;
      $display("error at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // only even columns of even lines are kept, oldest byte lowest
  task automatic record_pixel(input pixel_t b, input int h, input int v);
    chunk_t c;
    if (h % 2 == 0 && v % 2 == 0) begin
      exp_data = {b, exp_data[chunk_width-1:8]};
      exp_n++;
      if (exp_n == pixels_per_chunk) begin
        c.data = exp_data;
        c.last = (h == h_active - 2) && (v == v_active - 2);
        exp_q.push_back(c);
        exp_n = 0;
      end
    end
  endtask

  // one line, pclk half period of 4 cycles, data set while pclk is low
  task automatic drive_line(input int v, input bit record, input bit extra_edges);
    pixel_t b;
    @(posedge clk_camera);
    cam.hsync <= 1'b1;
    for (int h = 0; h < h_active; h++) begin
      next_pixel(b);
      if (record) record_pixel(b, h, v);
      @(posedge clk_camera);
      cam.data <= b;
      cam.pclk <= 1'b0;
      repeat (3) @(posedge clk_camera);
      @(posedge clk_camera);
      cam.pclk <= 1'b1;
      repeat (3) @(posedge clk_camera);
    end
    @(posedge clk_camera);
    cam.pclk  <= 1'b0;
    cam.hsync <= 1'b0;
    repeat (4) begin  // line gap, optionally with stray pclk edges
      repeat (4) @(posedge clk_camera);
      cam.pclk <= extra_edges ? !cam.pclk : 1'b0;
    end
  endtask

  task automatic drive_frame(input bit extra_edges);
    exp_q.delete();
    rx_q.delete();
    exp_n = 0;
    @(posedge clk_camera);
    cam.vsync <= 1'b1;
    repeat (16) @(posedge clk_camera);
    cam.vsync <= 1'b0;
    repeat (8) @(posedge clk_camera);
    for (int v = 0; v < v_active; v++) begin
      drive_line(v, 1'b1, extra_edges);
    end
  endtask

  task automatic compare_frame(input string what);
    while (rx_q.size() < exp_q.size()) @(posedge clk_camera);
    repeat (32) @(posedge clk_camera);  // catch any extra beat
    check_number(rx_q.size(), exp_q.size(), {what, " chunk count"});
    for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
      check_chunk(rx_q[i], exp_q[i], what);
    end
  endtask

  // low stretches stay under the 256 cycles a chunk takes to fill
  task automatic stall_ready();
    int low_len;
    int high_len;
    while (!frame_done) begin
      ready_bits(7, low_len);
      @(posedge clk_camera);
      chunk_ready <= 1'b0;
      repeat (low_len) @(posedge clk_camera);
      ready_bits(3, high_len);
      @(posedge clk_camera);
      chunk_ready <= 1'b1;
      repeat (high_len) @(posedge clk_camera);
    end
  endtask

  task automatic test_idle_after_reset();
    check_flag(chunk_valid, 1'b0, "chunk_valid after reset");
    check_flag(overrun, 1'b0, "overrun after reset");
    @(posedge clk_camera);
    chunk_ready <= 1'b1;
    drive_line(0, 1'b0, 1'b1);  // no vsync seen yet
    repeat (32) @(posedge clk_camera);
    check_number(rx_q.size(), 0, "chunks before first vsync");
    check_flag(chunk_valid, 1'b0, "chunk_valid before first vsync");
  endtask

  task automatic test_full_frame();
    drive_frame(1'b0);
    compare_frame("full frame");
    check_flag(overrun, 1'b0, "overrun after full frame");
  endtask

  task automatic test_short_stalls();
    frame_done = 1'b0;
    fork
      begin
        drive_frame(1'b0);
        frame_done = 1'b1;
      end
      stall_ready();
    join
    compare_frame("frame with short stalls");
    check_flag(overrun, 1'b0, "overrun after short stalls");
  endtask

  task automatic test_hsync_low_edges();
    drive_frame(1'b1);
    compare_frame("frame with pclk edges outside lines");
  endtask

  task automatic test_overrun();
    @(posedge clk_camera);
    chunk_ready <= 1'b0;
    drive_frame(1'b0);
    check_flag(overrun, 1'b1, "overrun after stalled frame");
    @(posedge clk_camera);
    chunk_ready <= 1'b1;
    repeat (32) @(posedge clk_camera);
    check_number(rx_q.size(), 1, "chunks from stalled frame");
    if (rx_q.size() > 0) check_chunk(rx_q[0], exp_q[0], "held chunk of stalled frame");
    drive_frame(1'b0);
    compare_frame("frame after overrun");
    check_flag(overrun, 1'b1, "overrun stays set");
  endtask

  initial begin
    sys_rst     = 1'b1;
    cam         = '0;
    chunk_ready = 1'b0;
    pix_lfsr    = 32'h3b25;
    ready_lfsr  = 32'h3b25;
    exp_data    = '0;
    exp_n       = 0;
    error_count = 0;
    checks_done = 0;
    frame_done  = 1'b0;
    repeat (2) @(posedge clk_camera);
    sys_rst <= 1'b0;
    @(posedge clk_camera);
    test_idle_after_reset();
    test_full_frame();
    test_short_stalls();
    test_hsync_low_edges();
    test_overrun();
    $display("checks: %0d  errors: %0d", checks_done, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
